// ==== tb.f ====
src/sink_pkg.sv
src/sink_addrgen.sv
src/sink_addr_fifo.sv
src/sink_store_align.sv
src/sink_ctrl.sv
src/sink_streamer.sv
sim/tb_sink_streamer.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the sink streamer testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_sink_streamer -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

// ==== sim/tb_sink_streamer.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_sink_streamer import sink_pkg::*; ();

  localparam int NUM_JOBS  = 12;
  localparam int MEM_BYTES = 8192;  // bases stay below 4096, so every job fits

  logic    clk_i, rst_ni, clear_i, start_i, ready_start_o, done_o;
  addr_t   base_addr_i;
  cnt_t    d0_len_i, tot_len_i;
  stride_t d0_stride_i, d1_stride_i;
  logic    stream_valid_i, stream_ready_o, mem_req_o, mem_gnt_i;
  sdata_t  stream_data_i;
  sstrb_t  stream_strb_i;
  addr_t   mem_addr_o;
  mbe_t    mem_be_o;
  mdata_t  mem_wdata_o;

  int   seed, errors, cycle_cnt, cycle_limit;
  int   tx_idx, rx_idx, done_cnt;  // beats sent, stores seen, done pulses
  bit   job_active;
  addr_t  cfg_base [NUM_JOBS];
  int     cfg_len0 [NUM_JOBS], cfg_rows [NUM_JOBS], cfg_s0 [NUM_JOBS], cfg_s1 [NUM_JOBS];
  bit     cfg_clear [NUM_JOBS];
  addr_t  exp_addr [$];
  sdata_t exp_data [$];
  sstrb_t exp_strb [$];
  logic [7:0] mem_model [MEM_BYTES];  // built from the DUT stores
  logic [7:0] shadow    [MEM_BYTES];  // built from the expected beats
  bit     stall_q;                    // request waited for grant last cycle
  addr_t  hold_addr;
  mbe_t   hold_be;
  mdata_t hold_wdata;

  sink_streamer i_dut (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [7:0] fill_byte(input int a);
    return a[7:0] ^ {3'b000, a[12:8]} ^ 8'h5a;  // every address bit counts
  endfunction

  // compare one granted store with the expected beat, then update both memories
  task automatic check_store();
    addr_t  a;
    sdata_t d;
    sstrb_t s;
    mbe_t   be_exp;
    mdata_t wd_exp;
    int     o, i, j;
    if (rx_idx >= exp_addr.size()) begin
      errors++;
      $display("FAIL %0t: store to %h after the last address of the job", $time, mem_addr_o);
    end else begin
      a      = exp_addr[rx_idx];
      d      = exp_data[rx_idx];
      s      = exp_strb[rx_idx];
      o      = int'(a[1:0]);
      be_exp = '0;
      wd_exp = '0;
      for (i = 0; i < MEM_BEW; i++) begin
        j = i - o;  // beat byte landing on lane i
        if (j >= 0 && j < 4) begin
          be_exp[i]         = s[j];
          wd_exp[i*8 +: 8] = d[j*8 +: 8];
        end
      end
      if (mem_addr_o != {a[ADDR_W-1:2], 2'b00}) begin
        errors++;
        $display("FAIL %0t: store %0d addr %h, expected %h", $time, rx_idx, mem_addr_o, a);
      end
      if (mem_be_o != be_exp || mem_wdata_o != wd_exp) begin
        errors++;
        $display("FAIL %0t: store %0d be %h data %h, expected be %h data %h", $time, rx_idx,
                 mem_be_o, mem_wdata_o, be_exp, wd_exp);
      end
      for (i = 0; i < MEM_BEW; i++) begin
        if (mem_be_o[i]) mem_model[int'(mem_addr_o[12:0]) + i] = mem_wdata_o[i*8 +: 8];
      end
      for (j = 0; j < 4; j++) begin
        if (s[j]) shadow[int'(a[12:0]) + j] = d[j*8 +: 8];
      end
      rx_idx++;
    end
  endtask

  task automatic compare_memory();
    int a;
    for (a = 0; a < MEM_BYTES; a++) begin
      if (mem_model[a] !== shadow[a]) begin
        errors++;
        $display("FAIL %0t: memory byte %h is %h, expected %h", $time, a, mem_model[a], shadow[a]);
      end
    end
  endtask

  // monitor, stream source and grant source
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("errors: %0d", errors);
        $display("STATUS: FAIL");
        $finish;
      end else begin
        if (mem_req_o && ready_start_o) begin
          errors++;
          $display("FAIL %0t: mem_req_o high while idle", $time);
        end
        if (stall_q && (!mem_req_o || mem_addr_o != hold_addr || mem_be_o != hold_be ||
                        mem_wdata_o != hold_wdata)) begin
          errors++;
          $display("FAIL %0t: store request changed before its grant", $time);
        end
        stall_q    = mem_req_o && !mem_gnt_i && !clear_i;  // clear drops the request
        hold_addr  = mem_addr_o;
        hold_be    = mem_be_o;
        hold_wdata = mem_wdata_o;
        if (mem_req_o && mem_gnt_i) check_store();
        if (done_o) begin
          done_cnt++;
          if (!job_active || rx_idx != exp_addr.size()) begin
            errors++;
            $display("FAIL %0t: done_o after %0d of %0d stores", $time, rx_idx, exp_addr.size());
          end
          if (!ready_start_o) begin
            errors++;
            $display("FAIL %0t: ready_start_o low with done_o", $time);
          end
        end
        if (stream_valid_i && stream_ready_o) tx_idx++;
        if (job_active && tx_idx < exp_data.size()) begin
          // a waiting beat stays put, otherwise a random gap
          if (!(stream_valid_i && !stream_ready_o))
            stream_valid_i <= ($unsigned($random(seed)) % 4) != 0;
          stream_data_i <= exp_data[tx_idx];
          stream_strb_i <= exp_strb[tx_idx];
        end else begin
          stream_valid_i <= 1'b0;
        end
        mem_gnt_i <= ($unsigned($random(seed)) % 3) != 0;  // low about a third of the time
      end
    end
  end

  task automatic run_job(input int k);
    int tot, n, dones;
    tot = cfg_len0[k] * cfg_rows[k];
    @(negedge clk_i);
    exp_addr.delete();
    exp_data.delete();
    exp_strb.delete();
    for (n = 0; n < tot; n++) begin
      exp_addr.push_back(cfg_base[k] + addr_t'((n % cfg_len0[k]) * cfg_s0[k])
                                     + addr_t'((n / cfg_len0[k]) * cfg_s1[k]));
      exp_data.push_back(sdata_t'($random(seed)));
      exp_strb.push_back(sstrb_t'($random(seed)));
    end
    tx_idx     = 0;
    rx_idx     = 0;
    dones      = done_cnt;
    job_active = 1'b1;
    @(posedge clk_i);
    base_addr_i <= cfg_base[k];
    d0_len_i    <= cnt_t'(cfg_len0[k]);
    d0_stride_i <= stride_t'(cfg_s0[k]);
    d1_stride_i <= stride_t'(cfg_s1[k]);
    tot_len_i   <= cnt_t'(tot);
    start_i     <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    if (cfg_clear[k]) begin
      while (rx_idx < tot / 2) @(negedge clk_i);
      @(posedge clk_i);
      clear_i <= 1'b1;  // abort halfway
      @(posedge clk_i);
      clear_i <= 1'b0;
      @(negedge clk_i);
      job_active = 1'b0;
    end else begin
      while (done_cnt == dones) @(negedge clk_i);
      job_active = 1'b0;
    end
    repeat (4) @(negedge clk_i);
    if (done_cnt != dones + (cfg_clear[k] ? 0 : 1)) begin
      errors++;
      $display("FAIL %0t: job %0d saw %0d done pulses", $time, k, done_cnt - dones);
    end
    if (!ready_start_o) begin
      errors++;
      $display("FAIL %0t: ready_start_o low after job %0d", $time, k);
    end
    compare_memory();
  endtask

  initial begin
    int k, total;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    start_i        = 1'b0;
    base_addr_i    = '0;
    d0_len_i       = '0;
    tot_len_i      = '0;
    d0_stride_i    = '0;
    d1_stride_i    = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    mem_gnt_i      = 1'b0;
    seed      = 5189;
    errors    = 0;
    cycle_cnt = 0;
    done_cnt  = 0;
    stall_q   = 1'b0;
    for (k = 0; k < MEM_BYTES; k++) begin
      mem_model[k] = fill_byte(k);
      shadow[k]    = fill_byte(k);
    end
    total = 0;
    for (k = 0; k < NUM_JOBS; k++) begin
      cfg_base[k]  = addr_t'($unsigned($random(seed)) % 4096);
      cfg_len0[k]  = 1 + int'($unsigned($random(seed)) % 8);
      cfg_rows[k]  = 1 + int'($unsigned($random(seed)) % 8);
      cfg_s0[k]    = int'($unsigned($random(seed)) % 13);
      cfg_s1[k]    = int'($unsigned($random(seed)) % 13);
      cfg_clear[k] = 1'b0;
    end
    cfg_base[0]  = cfg_base[0] & ~addr_t'(3);  // aligned and contiguous
    cfg_s0[0]    = 4;
    cfg_s1[0]    = 4 * cfg_len0[0];
    cfg_base[1]  = (cfg_base[1] & ~addr_t'(3)) | addr_t'(1);  // misaligned, odd strides
    cfg_s0[1]    = 5;
    cfg_s1[1]    = 11;
    cfg_len0[5]  = 4;  // aborted by clear
    cfg_rows[5]  = 4;
    cfg_clear[5] = 1'b1;
    for (k = 0; k < NUM_JOBS; k++) total += cfg_len0[k] * cfg_rows[k];
    cycle_limit = 40 * total + 2000;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (!ready_start_o || done_o) begin
      errors++;
      $display("FAIL %0t: flags after reset ready %b done %b", $time, ready_start_o, done_o);
    end
    for (k = 0; k < NUM_JOBS; k++) run_job(k);
    $display("errors: %0d", errors);
    if (errors == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/sink_streamer.sv ====
`default_nettype none
`timescale 1ns/10ps

module sink_streamer
  import sink_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    clear_i,

  // job control
  input  logic    start_i,
  output logic    ready_start_o,
  output logic    done_o,

  // job configuration, stable during a job
  input  addr_t   base_addr_i,
  input  cnt_t    d0_len_i,
  input  stride_t d0_stride_i,
  input  stride_t d1_stride_i,
  input  cnt_t    tot_len_i,

  // incoming stream
  input  logic    stream_valid_i,
  output logic    stream_ready_o,
  input  sdata_t  stream_data_i,
  input  sstrb_t  stream_strb_i,

  // memory store port
  output logic    mem_req_o,
  input  logic    mem_gnt_i,
  output addr_t   mem_addr_o,
  output mbe_t    mem_be_o,
  output mdata_t  mem_wdata_o
);

  logic  gen_valid, gen_ready, gen_done;
  addr_t gen_addr;
  logic  pop_valid, pop_ready;
  addr_t pop_addr;
  logic  store_fire;
  logic  gen_en, gen_clr;

  sink_addrgen i_addrgen (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .en_i        ( gen_en      ),
    .clr_i       ( gen_clr     ),
    .start_i     ( start_i     ),
    .base_addr_i ( base_addr_i ),
    .d0_len_i    ( d0_len_i    ),
    .d0_stride_i ( d0_stride_i ),
    .d1_stride_i ( d1_stride_i ),
    .tot_len_i   ( tot_len_i   ),
    .gen_ready_i ( gen_ready   ),
    .gen_valid_o ( gen_valid   ),
    .gen_addr_o  ( gen_addr    ),
    .gen_done_o  ( gen_done    )
  );

  sink_addr_fifo i_addr_fifo (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .clear_i      ( clear_i   ),
    .push_valid_i ( gen_valid ),
    .push_addr_i  ( gen_addr  ),
    .push_ready_o ( gen_ready ),
    .pop_valid_o  ( pop_valid ),
    .pop_addr_o   ( pop_addr  ),
    .pop_ready_i  ( pop_ready )
  );

  sink_store_align i_store_align (
    .pop_valid_i    ( pop_valid      ),
    .pop_addr_i     ( pop_addr       ),
    .pop_ready_o    ( pop_ready      ),
    .stream_valid_i ( stream_valid_i ),
    .stream_ready_o ( stream_ready_o ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .mem_req_o      ( mem_req_o      ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_be_o       ( mem_be_o       ),
    .mem_wdata_o    ( mem_wdata_o    ),
    .store_fire_o   ( store_fire     )
  );

  sink_ctrl i_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( start_i       ),
    .tot_len_i     ( tot_len_i     ),
    .gen_done_i    ( gen_done      ),
    .store_fire_i  ( store_fire    ),
    .gen_en_o      ( gen_en        ),
    .gen_clr_o     ( gen_clr       ),
    .ready_start_o ( ready_start_o ),
    .done_o        ( done_o        )
  );

endmodule

`default_nettype wire

// ==== src/sink_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module sink_ctrl
  import sink_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic start_i,
  input  cnt_t tot_len_i,
  input  logic gen_done_i,
  input  logic store_fire_i,
  output logic gen_en_o,
  output logic gen_clr_o,
  output logic ready_start_o,
  output logic done_o
);

  sink_state_e state_q, state_d;

  cnt_t store_cnt_q;  // stores granted in this job
  logic finish;       // last store accounted for
  logic done_q;

  assign finish = (state_q == DRAIN) && (store_cnt_q == tot_len_i);

  always_comb begin
    state_d  = state_q;
    gen_en_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d  = WORKING;
          gen_en_o = 1'b1;  // lets the generator sample the job
        end
      end
      WORKING: begin
        gen_en_o = 1'b1;
        if (gen_done_i) state_d = DRAIN;
      end
      DRAIN: begin
        gen_en_o = ~finish;
        if (finish) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  assign gen_clr_o     = clear_i | finish;  // rearm generator for next job
  assign ready_start_o = (state_q == IDLE);
  assign done_o        = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      store_cnt_q <= '0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      state_q     <= IDLE;
      store_cnt_q <= '0;
      done_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= finish;  // one cycle pulse after leaving DRAIN
      if (finish) store_cnt_q <= '0;
      else if (store_fire_i) store_cnt_q <= store_cnt_q + cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== src/sink_store_align.sv ====
`default_nettype none
`timescale 1ns/10ps

module sink_store_align
  import sink_pkg::*;
(
  // address side
  input  logic   pop_valid_i,
  input  addr_t  pop_addr_i,
  output logic   pop_ready_o,

  // stream side
  input  logic   stream_valid_i,
  output logic   stream_ready_o,
  input  sdata_t stream_data_i,
  input  sstrb_t stream_strb_i,

  // memory store port
  output logic   mem_req_o,
  input  logic   mem_gnt_i,
  output addr_t  mem_addr_o,
  output mbe_t   mem_be_o,
  output mdata_t mem_wdata_o,

  output logic   store_fire_o  // one pulse per accepted store
);

  // one pre-shifted copy of the beat per possible bank offset
  mdata_t data_shift [ELEMS_PER_BANK];
  mbe_t   be_shift   [ELEMS_PER_BANK];

  logic [OFFS_W-1:0] bank_offs;  // byte offset inside the 32-bit bank

  assign bank_offs = pop_addr_i[OFFS_W-1:0];

  for (genvar offs = 0; offs < ELEMS_PER_BANK; offs++) begin : gen_shift
    // beat lands at byte lane offs, upper bank takes the spill
    assign data_shift[offs] = mdata_t'(stream_data_i) << (offs * ELEM_W);
    assign be_shift[offs]   = mbe_t'(stream_strb_i) << offs;
  end

  // request only when an address and a beat meet
  assign mem_req_o = pop_valid_i & stream_valid_i;

  // word-aligned address, low offset bits cleared
  assign mem_addr_o  = {pop_addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
  assign mem_wdata_o = data_shift[bank_offs];
  assign mem_be_o    = be_shift[bank_offs];

  // address and beat leave together on the grant
  assign store_fire_o   = mem_req_o & mem_gnt_i;
  assign pop_ready_o    = store_fire_o;
  assign stream_ready_o = store_fire_o;  // low gnt keeps the beat waiting

endmodule

`default_nettype wire

// ==== src/sink_addr_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module sink_addr_fifo
  import sink_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  push_valid_i,
  input  addr_t push_addr_i,
  output logic  push_ready_o,
  output logic  pop_valid_o,
  output addr_t pop_addr_o,
  input  logic  pop_ready_i
);

  addr_t mem_q [ADDR_FIFO_DEPTH];

  logic [$clog2(ADDR_FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(ADDR_FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(ADDR_FIFO_DEPTH+1)-1:0] used_q;  // occupancy

  logic push;
  logic pop;

  assign push_ready_o = (used_q != ADDR_FIFO_DEPTH);  // full stalls the generator
  assign pop_valid_o  = (used_q != '0);
  assign pop_addr_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      used_q   <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      used_q   <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == ADDR_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == ADDR_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   used_q <= used_q + 1'b1;
        2'b01:   used_q <= used_q - 1'b1;
        default: used_q <= used_q;  // none or both
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_addr_i;
  end

endmodule

`default_nettype wire

// ==== src/sink_addrgen.sv ====
`default_nettype none
`timescale 1ns/10ps

module sink_addrgen
  import sink_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    en_i,
  input  logic    clr_i,
  input  logic    start_i,
  input  addr_t   base_addr_i,
  input  cnt_t    d0_len_i,
  input  stride_t d0_stride_i,
  input  stride_t d1_stride_i,
  input  cnt_t    tot_len_i,
  input  logic    gen_ready_i,
  output logic    gen_valid_o,
  output addr_t   gen_addr_o,
  output logic    gen_done_o
);

  // sampled job configuration
  cnt_t    d0_len_q;
  cnt_t    tot_len_q;
  stride_t d0_stride_q;
  stride_t d1_stride_q;

  addr_t   row_base_q;    // base of the current outer row
  stride_t inner_offs_q;  // running inner offset inside the row
  cnt_t    inner_idx_q;   // position inside the row
  cnt_t    tot_cnt_q;     // addresses handed out so far
  logic    running_q;
  logic    finished_q;    // blocks a restart until the controller clears us

  logic start_ok;
  logic xfer;
  logic last_inner;
  logic last_addr;

  assign start_ok   = en_i & start_i & ~running_q & ~finished_q;
  assign xfer       = gen_valid_o & gen_ready_i;
  assign last_inner = (inner_idx_q == d0_len_q - cnt_t'(1));  // end of row
  assign last_addr  = (tot_cnt_q == tot_len_q - cnt_t'(1));

  assign gen_valid_o = running_q & en_i;
  assign gen_addr_o  = row_base_q + addr_t'(inner_offs_q);
  assign gen_done_o  = xfer & last_addr;  // same cycle as the last transfer

  // control state and counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q   <= 1'b0;
      finished_q  <= 1'b0;
      inner_idx_q <= '0;
      tot_cnt_q   <= '0;
    end else if (clr_i) begin
      running_q   <= 1'b0;
      finished_q  <= 1'b0;
      inner_idx_q <= '0;
      tot_cnt_q   <= '0;
    end else if (start_ok) begin
      running_q   <= 1'b1;  // first address valid next cycle
      inner_idx_q <= '0;
      tot_cnt_q   <= '0;
    end else if (xfer) begin
      tot_cnt_q <= tot_cnt_q + cnt_t'(1);
      if (last_addr) begin
        running_q  <= 1'b0;
        finished_q <= 1'b1;
      end
      inner_idx_q <= last_inner ? '0 : inner_idx_q + cnt_t'(1);
    end
  end

  // config sample and address datapath
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      d0_len_q     <= d0_len_i;
      tot_len_q    <= tot_len_i;
      d0_stride_q  <= d0_stride_i;
      d1_stride_q  <= d1_stride_i;
      row_base_q   <= base_addr_i;
      inner_offs_q <= '0;
    end else if (xfer) begin
      if (last_inner) begin
        // wrap the row and step to the next outer position
        inner_offs_q <= '0;
        row_base_q   <= row_base_q + addr_t'(d1_stride_q);
      end else begin
        inner_offs_q <= inner_offs_q + d0_stride_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/sink_pkg.sv ====
`default_nettype none

package sink_pkg;

  // element and bank geometry
  localparam int unsigned ELEM_W         = 8;  // one byte per element
  localparam int unsigned ELEMS_PER_BANK = 4;  // bytes in a 32-bit bank

  // data widths
  localparam int unsigned STREAM_DW = ELEM_W * ELEMS_PER_BANK;       // 32
  localparam int unsigned MEM_DW    = STREAM_DW + ELEM_W * ELEMS_PER_BANK; // one spare bank
  localparam int unsigned MEM_BEW   = MEM_DW / ELEM_W;               // 8 byte enables

  // addressing
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned OFFS_W = $clog2(ELEMS_PER_BANK); // byte offset in bank

  localparam int unsigned CNT_W           = 16; // length and transaction counters
  localparam int unsigned ADDR_FIFO_DEPTH = 2;

  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [STREAM_DW-1:0]        sdata_t;
  typedef logic [STREAM_DW/ELEM_W-1:0] sstrb_t;  // one strobe per stream byte
  typedef logic [MEM_DW-1:0]           mdata_t;
  typedef logic [MEM_BEW-1:0]          mbe_t;
  typedef logic [CNT_W-1:0]            cnt_t;
  typedef logic signed [ADDR_W-1:0]    stride_t; // strides may walk backwards

  // job controller
  typedef enum logic [1:0] {
    IDLE,     // waiting for start
    WORKING,  // generator still producing addresses
    DRAIN     // all addresses out, waiting for the last grants
  } sink_state_e;

endpackage

`default_nettype wire
